//--- files.f
src/core_types_pkg.sv
src/prf_req_if.sv
src/pe_lsb.sv
src/alu_reg_mdu_iq.sv
src/prf_read_bank_router.sv
src/alu_reg_mdu_issue_top.sv
tests/tb_alu_reg_mdu_issue.sv

//--- run.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_alu_reg_mdu_issue \
    -o tb_alu_reg_mdu_issue && ./obj_dir/tb_alu_reg_mdu_issue | tee sim.log
grep -q "^Simulation PASSED$" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

//--- src/alu_reg_mdu_iq.sv
module alu_reg_mdu_iq #(
    parameter int IQ_ENTRIES = 12
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue from dispatch
    input  logic                      enq_valid,
    input  logic                      enq_is_alu_reg,
    input  logic                      enq_is_mdu,
    input  core_types_pkg::op_t       enq_op,
    input  core_types_pkg::pr_t       enq_a_pr,
    input  logic                      enq_a_ready,
    input  logic                      enq_a_is_zero,
    input  core_types_pkg::pr_t       enq_b_pr,
    input  logic                      enq_b_ready,
    input  logic                      enq_b_is_zero,
    input  core_types_pkg::pr_t       enq_dest_pr,
    input  core_types_pkg::rob_idx_t  enq_rob_index,
    output logic                      enq_ready,

    // writeback bus, one slot per bank
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

    // issue to ALU reg and MDU pipelines
    output logic                      alu_reg_issue_valid,
    output logic                      mdu_issue_valid,
    output core_types_pkg::op_t       issue_op,
    output logic                      issue_a_forward,
    output logic                      issue_a_is_zero,
    output core_types_pkg::pr_t       issue_a_pr,
    output logic                      issue_b_forward,
    output logic                      issue_b_is_zero,
    output core_types_pkg::pr_t       issue_b_pr,
    output core_types_pkg::pr_t       issue_dest_pr,
    output core_types_pkg::rob_idx_t  issue_rob_index,
    input  logic                      alu_reg_issue_ready,
    input  logic                      mdu_issue_ready,

    // register file read requests for the issued op
    prf_req_if.producer               prf_req
);

    import core_types_pkg::*;

    // one queue slot
    typedef struct packed {
        logic     is_alu_reg;
        logic     is_mdu;
        op_t      op;
        pr_t      a_pr;
        logic     a_ready;
        logic     a_is_zero;
        pr_t      b_pr;
        logic     b_ready;
        logic     b_is_zero;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } entry_t;

    // ----------------------------------------
    // signals

    // slot 0 is always the oldest
    logic   [IQ_ENTRIES-1:0] valid_q;
    logic   [IQ_ENTRIES-1:0] valid_d;
    entry_t [IQ_ENTRIES-1:0] entry_q;
    entry_t [IQ_ENTRIES-1:0] entry_d;

    // entries with this cycle's wakeup folded into the ready bits
    entry_t [IQ_ENTRIES-1:0] held_entry;
    entry_t [IQ_ENTRIES-1:0] held_above;
    logic   [IQ_ENTRIES-1:0] valid_above;

    logic [IQ_ENTRIES-1:0] a_forward;
    logic [IQ_ENTRIES-1:0] b_forward;

    logic [IQ_ENTRIES-1:0] issue_ready_by_entry;
    logic [IQ_ENTRIES-1:0] issue_one_hot;
    logic [IQ_ENTRIES-1:0] issue_mask;

    logic [IQ_ENTRIES-1:0] free_one_hot;
    logic [IQ_ENTRIES-1:0] dispatch_one_hot;
    logic [IQ_ENTRIES-1:0] dispatch_above;

    entry_t enq_entry;

    // ----------------------------------------
    // wakeup

    // register is on the writeback bus for its bank
    function automatic logic wb_hit(
        input pr_t pr,
        input logic [PRF_BANK_COUNT-1:0] wb_valid,
        input upper_pr_t [PRF_BANK_COUNT-1:0] wb_upper
    );
        logic [LOG_PRF_BANK_COUNT-1:0] bank;
        bank = pr[LOG_PRF_BANK_COUNT-1:0];
        return wb_valid[bank] && (wb_upper[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            a_forward[i] = wb_hit(entry_q[i].a_pr, wb_valid_by_bank, wb_upper_pr_by_bank);
            b_forward[i] = wb_hit(entry_q[i].b_pr, wb_valid_by_bank, wb_upper_pr_by_bank);

            // ready bits are sticky once forwarded
            held_entry[i] = entry_q[i];
            held_entry[i].a_ready = entry_q[i].a_ready | a_forward[i];
            held_entry[i].b_ready = entry_q[i].b_ready | b_forward[i];
        end
    end

    // ----------------------------------------
    // issue select

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            issue_ready_by_entry[i] = valid_q[i]
                & ((entry_q[i].is_alu_reg & alu_reg_issue_ready)
                    | (entry_q[i].is_mdu & mdu_issue_ready))
                & (entry_q[i].a_ready | a_forward[i] | entry_q[i].a_is_zero)
                & (entry_q[i].b_ready | b_forward[i] | entry_q[i].b_is_zero);
        end
    end

    // lowest index is oldest
    pe_lsb #(.WIDTH(IQ_ENTRIES)) issue_pe_i (
        .req_vec     (issue_ready_by_entry),
        .ack_one_hot (issue_one_hot),
        .ack_mask    (issue_mask)
    );

    // one-hot mux of the winner
    always_comb begin
        alu_reg_issue_valid = 1'b0;
        mdu_issue_valid = 1'b0;
        issue_op = '0;
        issue_a_forward = 1'b0;
        issue_a_is_zero = 1'b0;
        issue_a_pr = '0;
        issue_b_forward = 1'b0;
        issue_b_is_zero = 1'b0;
        issue_b_pr = '0;
        issue_dest_pr = '0;
        issue_rob_index = '0;
        prf_req.a_valid = 1'b0;
        prf_req.b_valid = 1'b0;

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_one_hot[i]) begin
                // only the winner's own pipeline sees valid
                alu_reg_issue_valid |= entry_q[i].is_alu_reg;
                mdu_issue_valid |= entry_q[i].is_mdu;
                issue_op |= entry_q[i].op;
                issue_a_forward |= a_forward[i];
                issue_a_is_zero |= entry_q[i].a_is_zero;
                issue_a_pr |= entry_q[i].a_pr;
                issue_b_forward |= b_forward[i];
                issue_b_is_zero |= entry_q[i].b_is_zero;
                issue_b_pr |= entry_q[i].b_pr;
                issue_dest_pr |= entry_q[i].dest_pr;
                issue_rob_index |= entry_q[i].rob_index;

                // forwarded and zero operands skip the register file
                prf_req.a_valid |= ~a_forward[i] & ~entry_q[i].a_is_zero;
                prf_req.b_valid |= ~b_forward[i] & ~entry_q[i].b_is_zero;
            end
        end
    end

    assign prf_req.a_pr = issue_a_pr;
    assign prf_req.b_pr = issue_b_pr;

    // ----------------------------------------
    // enqueue

    pe_lsb #(.WIDTH(IQ_ENTRIES)) free_pe_i (
        .req_vec     (~valid_q),
        .ack_one_hot (free_one_hot),
        .ack_mask    ()
    );

    assign enq_ready = ~&valid_q;
    assign dispatch_one_hot = free_one_hot & {IQ_ENTRIES{enq_valid}};

    always_comb begin
        enq_entry.is_alu_reg = enq_is_alu_reg;
        enq_entry.is_mdu = enq_is_mdu;
        enq_entry.op = enq_op;
        enq_entry.a_pr = enq_a_pr;
        enq_entry.a_ready = enq_a_ready;
        enq_entry.a_is_zero = enq_a_is_zero;
        enq_entry.b_pr = enq_b_pr;
        enq_entry.b_ready = enq_b_ready;
        enq_entry.b_is_zero = enq_b_is_zero;
        enq_entry.dest_pr = enq_dest_pr;
        enq_entry.rob_index = enq_rob_index;
    end

    // ----------------------------------------
    // collapse

    // view of the slot above, nothing above the top slot
    assign valid_above = {1'b0, valid_q[IQ_ENTRIES-1:1]};
    assign dispatch_above = {1'b0, dispatch_one_hot[IQ_ENTRIES-1:1]};
    assign held_above = {held_entry[IQ_ENTRIES-1], held_entry[IQ_ENTRIES-1:1]};

    // slots at or above the issued one pull from above
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_mask[i] ? valid_above[i] : valid_q[i]) begin
                valid_d[i] = 1'b1;
                entry_d[i] = issue_mask[i] ? held_above[i] : held_entry[i];
            end else begin
                // empty source, so the new op may land here
                valid_d[i] = issue_mask[i] ? dispatch_above[i] : dispatch_one_hot[i];
                entry_d[i] = enq_entry;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        entry_q <= entry_d;
    end

    // ----------------------------------------
    // assertions

    a_enq_one_kind: assert property (@(posedge CLK) disable iff (!nRST)
        enq_valid && enq_ready |-> enq_is_alu_reg ^ enq_is_mdu);

    a_issue_one_pipe: assert property (@(posedge CLK) disable iff (!nRST)
        !(alu_reg_issue_valid && mdu_issue_valid));

    // valid slots form a solid block from slot 0
    a_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        alu_reg_issue_valid || mdu_issue_valid
        |=> ((valid_q + {{(IQ_ENTRIES-1){1'b0}}, 1'b1}) & valid_q) == '0);

endmodule

//--- src/alu_reg_mdu_issue_top.sv
module alu_reg_mdu_issue_top #(
    parameter int IQ_ENTRIES = 12
) (
    input  logic CLK,
    input  logic nRST,

    // enqueue
    input  logic                      enq_valid,
    input  logic                      enq_is_alu_reg,
    input  logic                      enq_is_mdu,
    input  core_types_pkg::op_t       enq_op,
    input  core_types_pkg::pr_t       enq_a_pr,
    input  logic                      enq_a_ready,
    input  logic                      enq_a_is_zero,
    input  core_types_pkg::pr_t       enq_b_pr,
    input  logic                      enq_b_ready,
    input  logic                      enq_b_is_zero,
    input  core_types_pkg::pr_t       enq_dest_pr,
    input  core_types_pkg::rob_idx_t  enq_rob_index,
    output logic                      enq_ready,

    // writeback bus
    input  logic [core_types_pkg::PRF_BANK_COUNT-1:0] wb_valid_by_bank,
    input  core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

    // issue
    output logic                      alu_reg_issue_valid,
    output logic                      mdu_issue_valid,
    output core_types_pkg::op_t       issue_op,
    output logic                      issue_a_forward,
    output logic                      issue_a_is_zero,
    output core_types_pkg::pr_t       issue_a_pr,
    output logic                      issue_b_forward,
    output logic                      issue_b_is_zero,
    output core_types_pkg::pr_t       issue_b_pr,
    output core_types_pkg::pr_t       issue_dest_pr,
    output core_types_pkg::rob_idx_t  issue_rob_index,
    input  logic                      alu_reg_issue_ready,
    input  logic                      mdu_issue_ready,

    // bank read ports
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0] rd_a_valid_by_bank,
    output core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] rd_a_row_by_bank,
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0] rd_b_valid_by_bank,
    output core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] rd_b_row_by_bank
);

    prf_req_if prf_req ();

    alu_reg_mdu_iq #(.IQ_ENTRIES(IQ_ENTRIES)) iq_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .enq_valid           (enq_valid),
        .enq_is_alu_reg      (enq_is_alu_reg),
        .enq_is_mdu          (enq_is_mdu),
        .enq_op              (enq_op),
        .enq_a_pr            (enq_a_pr),
        .enq_a_ready         (enq_a_ready),
        .enq_a_is_zero       (enq_a_is_zero),
        .enq_b_pr            (enq_b_pr),
        .enq_b_ready         (enq_b_ready),
        .enq_b_is_zero       (enq_b_is_zero),
        .enq_dest_pr         (enq_dest_pr),
        .enq_rob_index       (enq_rob_index),
        .enq_ready           (enq_ready),
        .wb_valid_by_bank    (wb_valid_by_bank),
        .wb_upper_pr_by_bank (wb_upper_pr_by_bank),
        .alu_reg_issue_valid (alu_reg_issue_valid),
        .mdu_issue_valid     (mdu_issue_valid),
        .issue_op            (issue_op),
        .issue_a_forward     (issue_a_forward),
        .issue_a_is_zero     (issue_a_is_zero),
        .issue_a_pr          (issue_a_pr),
        .issue_b_forward     (issue_b_forward),
        .issue_b_is_zero     (issue_b_is_zero),
        .issue_b_pr          (issue_b_pr),
        .issue_dest_pr       (issue_dest_pr),
        .issue_rob_index     (issue_rob_index),
        .alu_reg_issue_ready (alu_reg_issue_ready),
        .mdu_issue_ready     (mdu_issue_ready),
        .prf_req             (prf_req.producer)
    );

    prf_read_bank_router router_i (
        .CLK                (CLK),
        .nRST               (nRST),
        .prf_req            (prf_req.consumer),
        .rd_a_valid_by_bank (rd_a_valid_by_bank),
        .rd_a_row_by_bank   (rd_a_row_by_bank),
        .rd_b_valid_by_bank (rd_b_valid_by_bank),
        .rd_b_row_by_bank   (rd_b_row_by_bank)
    );

endmodule

//--- src/core_types_pkg.sv
package core_types_pkg;

    // ----------------------------------------
    // physical register file

    // 64 physical registers
    localparam int LOG_PR_COUNT = 6;

    // banks are selected by the low bits of a register index
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT = 1 << LOG_PRF_BANK_COUNT;

    // ----------------------------------------
    // reorder buffer

    localparam int LOG_ROB_ENTRIES = 6;

    // ----------------------------------------
    // shared types

    // full physical register index
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // row within a bank, bank bits stripped
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;

    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;

    // function code, opaque to the issue stage
    typedef logic [3:0] op_t;

endpackage

//--- src/pe_lsb.sv
module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req_vec,
    output logic [WIDTH-1:0] ack_one_hot,
    output logic [WIDTH-1:0] ack_mask
);

    // set once the lowest request has been seen
    logic found;

    // walk up from bit 0, the first request wins
    always_comb begin
        found = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            ack_one_hot[i] = req_vec[i] & ~found;
            found = found | req_vec[i];
            // winner and everything above it
            ack_mask[i] = found;
        end
    end

endmodule

//--- src/prf_read_bank_router.sv
module prf_read_bank_router (
    input  logic CLK,
    input  logic nRST,

    prf_req_if.consumer prf_req,

    // per-bank read ports, registered
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0] rd_a_valid_by_bank,
    output core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] rd_a_row_by_bank,
    output logic [core_types_pkg::PRF_BANK_COUNT-1:0] rd_b_valid_by_bank,
    output core_types_pkg::upper_pr_t [core_types_pkg::PRF_BANK_COUNT-1:0] rd_b_row_by_bank
);

    import core_types_pkg::*;

    logic [LOG_PRF_BANK_COUNT-1:0] a_bank;
    logic [LOG_PRF_BANK_COUNT-1:0] b_bank;
    upper_pr_t a_row;
    upper_pr_t b_row;
    logic [PRF_BANK_COUNT-1:0] a_valid_d;
    logic [PRF_BANK_COUNT-1:0] b_valid_d;

    // ----------------------------------------
    // bank decode

    // bank in the low bits, row in the rest
    assign a_bank = prf_req.a_pr[LOG_PRF_BANK_COUNT-1:0];
    assign a_row = prf_req.a_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
    assign b_bank = prf_req.b_pr[LOG_PRF_BANK_COUNT-1:0];
    assign b_row = prf_req.b_pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];

    always_comb begin
        a_valid_d = '0;
        b_valid_d = '0;
        a_valid_d[a_bank] = prf_req.a_valid;
        b_valid_d[b_bank] = prf_req.b_valid;
    end

    // ----------------------------------------
    // read port registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_a_valid_by_bank <= '0;
            rd_b_valid_by_bank <= '0;
        end else begin
            rd_a_valid_by_bank <= a_valid_d;
            rd_b_valid_by_bank <= b_valid_d;
        end
    end

    // rows only move when their bank is requested
    always_ff @(posedge CLK) begin
        for (int k = 0; k < PRF_BANK_COUNT; k++) begin
            if (a_valid_d[k]) begin
                rd_a_row_by_bank[k] <= a_row;
            end
            if (b_valid_d[k]) begin
                rd_b_row_by_bank[k] <= b_row;
            end
        end
    end

    // ----------------------------------------
    // assertions

    a_one_port_each: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(rd_a_valid_by_bank) && $onehot0(rd_b_valid_by_bank));

endmodule

//--- src/prf_req_if.sv
interface prf_req_if;

    import core_types_pkg::*;

    // operand A read request
    logic a_valid;
    pr_t  a_pr;

    // operand B read request
    logic b_valid;
    pr_t  b_pr;

    // issue queue side
    modport producer (
        output a_valid,
        output a_pr,
        output b_valid,
        output b_pr
    );

    // bank router side
    modport consumer (
        input a_valid,
        input a_pr,
        input b_valid,
        input b_pr
    );

endinterface

//--- tests/tb_alu_reg_mdu_issue.sv
module tb_alu_reg_mdu_issue;

    import core_types_pkg::*;

    localparam int IQ_ENTRIES = 12;
    localparam int TIMEOUT = 64;

    // one op as the testbench tracks it
    typedef struct packed {
        logic     mdu;
        op_t      op;
        pr_t      a;
        logic     a_ready;
        logic     a_zero;
        pr_t      b;
        logic     b_ready;
        logic     b_zero;
        pr_t      dest;
        rob_idx_t rob;
    } op_rec_t;

    logic CLK;
    logic nRST;
    logic enq_valid, enq_is_alu_reg, enq_is_mdu, enq_ready;
    logic enq_a_ready, enq_a_is_zero, enq_b_ready, enq_b_is_zero;
    op_t enq_op, issue_op;
    pr_t enq_a_pr, enq_b_pr, enq_dest_pr;
    pr_t issue_a_pr, issue_b_pr, issue_dest_pr;
    rob_idx_t enq_rob_index, issue_rob_index;
    logic alu_reg_issue_valid, mdu_issue_valid, alu_reg_issue_ready, mdu_issue_ready;
    logic issue_a_forward, issue_a_is_zero, issue_b_forward, issue_b_is_zero;
    logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank, rd_a_valid_by_bank, rd_b_valid_by_bank;
    upper_pr_t [PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank, rd_a_row_by_bank, rd_b_row_by_bank;

    int errors;
    int checks;
    int tests_failed;
    int test_start;
    logic [31:0] rng;

    alu_reg_mdu_issue_top #(.IQ_ENTRIES(IQ_ENTRIES)) alu_reg_mdu_issue_top_i (.*);

    always #20 CLK = ~CLK;

    // ----------------------------------------
    // expected values

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // random registers and code, ready and nonzero operands
    function automatic op_rec_t random_op(input logic mdu, input int rob);
        op_rec_t r;
        rng = xorshift(rng);
        r = '0;
        r.mdu = mdu;
        r.op = rng[3:0];
        r.a = rng[9:4];
        r.b = rng[15:10];
        r.dest = rng[21:16];
        r.rob = rob_idx_t'(rob);
        r.a_ready = 1'b1;
        r.b_ready = 1'b1;
        return r;
    endfunction

    function automatic logic [LOG_PRF_BANK_COUNT-1:0] bank_of(input pr_t p);
        return p[LOG_PRF_BANK_COUNT-1:0];
    endfunction

    function automatic upper_pr_t row_of(input pr_t p);
        return p[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
    endfunction

    function automatic logic [PRF_BANK_COUNT-1:0] bank_bit(input pr_t p);
        logic [PRF_BANK_COUNT-1:0] v;
        v = '0;
        v[bank_of(p)] = 1'b1;
        return v;
    endfunction

    // ----------------------------------------
    // compare tasks

    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        errors++;
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    task automatic check_pr(input string name, input pr_t got, input pr_t exp);
        checks++;
        if (got !== exp)
            note_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_rob(input string name, input rob_idx_t got, input rob_idx_t exp);
        checks++;
        if (got !== exp)
            note_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_op(input string name, input op_t got, input op_t exp);
        checks++;
        if (got !== exp)
            note_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
            note_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_row(input string name, input upper_pr_t got, input upper_pr_t exp);
        checks++;
        if (got !== exp)
            note_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_banks(input string name, input logic [PRF_BANK_COUNT-1:0] got,
                               input logic [PRF_BANK_COUNT-1:0] exp);
        checks++;
        if (got !== exp)
            note_mismatch(name, 32'(got), 32'(exp));
    endtask

    // every issue field, sampled in the issue cycle
    task automatic check_issued(input op_rec_t r, input logic a_fwd, input logic b_fwd);
        check_bit("alu_reg_issue_valid", alu_reg_issue_valid, ~r.mdu);
        check_bit("mdu_issue_valid", mdu_issue_valid, r.mdu);
        check_op("issue_op", issue_op, r.op);
        check_pr("issue_a_pr", issue_a_pr, r.a);
        check_bit("issue_a_forward", issue_a_forward, a_fwd);
        check_bit("issue_a_is_zero", issue_a_is_zero, r.a_zero);
        check_pr("issue_b_pr", issue_b_pr, r.b);
        check_bit("issue_b_forward", issue_b_forward, b_fwd);
        check_bit("issue_b_is_zero", issue_b_is_zero, r.b_zero);
        check_pr("issue_dest_pr", issue_dest_pr, r.dest);
        check_rob("issue_rob_index", issue_rob_index, r.rob);
    endtask

    // bank ports one cycle after the issue
    task automatic check_read_ports(input op_rec_t r, input logic a_fwd, input logic b_fwd);
        logic a_req;
        logic b_req;
        a_req = ~a_fwd & ~r.a_zero;
        b_req = ~b_fwd & ~r.b_zero;
        check_banks("rd_a_valid_by_bank", rd_a_valid_by_bank, a_req ? bank_bit(r.a) : '0);
        check_banks("rd_b_valid_by_bank", rd_b_valid_by_bank, b_req ? bank_bit(r.b) : '0);
        if (a_req)
            check_row("rd_a_row_by_bank", rd_a_row_by_bank[bank_of(r.a)], row_of(r.a));
        if (b_req)
            check_row("rd_b_row_by_bank", rd_b_row_by_bank[bank_of(r.b)], row_of(r.b));
    endtask

    // ----------------------------------------
    // drive and wait

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation FAILED");
        $finish;
    endtask

    // starts at a falling edge, returns one cycle after acceptance
    task automatic enqueue(input op_rec_t r);
        int n;
        enq_valid = 1'b1;
        enq_is_alu_reg = ~r.mdu;
        enq_is_mdu = r.mdu;
        enq_op = r.op;
        enq_a_pr = r.a;
        enq_a_ready = r.a_ready;
        enq_a_is_zero = r.a_zero;
        enq_b_pr = r.b;
        enq_b_ready = r.b_ready;
        enq_b_is_zero = r.b_zero;
        enq_dest_pr = r.dest;
        enq_rob_index = r.rob;
        n = 0;
        #10;
        while (!enq_ready && n < TIMEOUT) begin
            @(negedge CLK);
            #10;
            n++;
        end
        if (!enq_ready) begin
            abort_on_timeout("enq_ready");
        end else begin
            @(negedge CLK);
            enq_valid = 1'b0;
        end
    endtask

    // returns at the sample point of the issue cycle
    task automatic wait_issue(input logic mdu);
        int n;
        n = 0;
        #10;
        while (!(mdu ? mdu_issue_valid : alu_reg_issue_valid) && n < TIMEOUT) begin
            @(negedge CLK);
            #10;
            n++;
        end
        if (!(mdu ? mdu_issue_valid : alu_reg_issue_valid))
            abort_on_timeout("an issue");
    endtask

    task automatic drain_queue;
        int n;
        alu_reg_issue_ready = 1'b1;
        mdu_issue_ready = 1'b1;
        n = 0;
        #10;
        while ((alu_reg_issue_valid || mdu_issue_valid) && n < TIMEOUT) begin
            @(negedge CLK);
            #10;
            n++;
        end
        if (alu_reg_issue_valid || mdu_issue_valid)
            abort_on_timeout("the queue to drain");
        else
            @(negedge CLK);
    endtask

    task automatic present_writeback(input pr_t p);
        wb_valid_by_bank = bank_bit(p);
        wb_upper_pr_by_bank[bank_of(p)] = row_of(p);
    endtask

    task automatic close_test(input string name);
        if (errors == test_start) begin
            $display("%-18s ok", name);
        end else begin
            $display("%-18s %0d mismatches", name, errors - test_start);
            tests_failed++;
        end
        test_start = errors;
    endtask

    // ----------------------------------------
    // directed tests

    task automatic after_reset;
        #10;
        check_bit("enq_ready", enq_ready, 1'b1);
        check_bit("alu_reg_issue_valid", alu_reg_issue_valid, 1'b0);
        check_bit("mdu_issue_valid", mdu_issue_valid, 1'b0);
        check_banks("rd_a_valid_by_bank", rd_a_valid_by_bank, '0);
        check_banks("rd_b_valid_by_bank", rd_b_valid_by_bank, '0);
        @(negedge CLK);
        close_test("after reset");
    endtask

    task automatic single_alu_op;
        op_rec_t r;
        alu_reg_issue_ready = 1'b1;
        r = random_op(1'b0, 5);
        enqueue(r);
        #10;
        check_issued(r, 1'b0, 1'b0);
        @(negedge CLK);
        #10;
        check_read_ports(r, 1'b0, 1'b0);
        @(negedge CLK);
        close_test("single alu op");
    endtask

    task automatic oldest_first;
        op_rec_t r[3];
        alu_reg_issue_ready = 1'b0;
        for (int k = 0; k < 3; k++) begin
            r[k] = random_op(1'b0, 10 + k);
            enqueue(r[k]);
        end
        alu_reg_issue_ready = 1'b1;
        wait_issue(1'b0);
        // one per cycle in enqueue order
        for (int k = 0; k < 3; k++) begin
            check_issued(r[k], 1'b0, 1'b0);
            @(negedge CLK);
            #10;
        end
        check_bit("alu_reg_issue_valid", alu_reg_issue_valid, 1'b0);
        @(negedge CLK);
        close_test("oldest first");
    endtask

    task automatic writeback_wakeup;
        op_rec_t m;
        op_rec_t l;
        alu_reg_issue_ready = 1'b1;
        mdu_issue_ready = 1'b0;
        m = random_op(1'b1, 20);
        m.a_ready = 1'b0;
        l = random_op(1'b0, 21);
        l.a = m.a ^ 6'h21;
        l.a_ready = 1'b0;
        l.b = l.a ^ 6'h03;
        // early wakeup for the stalled mdu op
        enqueue(m);
        present_writeback(m.a);
        #10;
        check_bit("mdu_issue_valid", mdu_issue_valid, 1'b0);
        @(negedge CLK);
        wb_valid_by_bank = '0;
        enqueue(l);
        #10;
        check_bit("alu_reg_issue_valid", alu_reg_issue_valid, 1'b0);
        @(negedge CLK);
        // same-cycle wakeup, A comes from the bypass
        present_writeback(l.a);
        #10;
        check_issued(l, 1'b1, 1'b0);
        @(negedge CLK);
        wb_valid_by_bank = '0;
        #10;
        check_read_ports(l, 1'b1, 1'b0);
        @(negedge CLK);
        mdu_issue_ready = 1'b1;
        #10;
        check_issued(m, 1'b0, 1'b0);
        @(negedge CLK);
        #10;
        check_read_ports(m, 1'b0, 1'b0);
        @(negedge CLK);
        close_test("writeback wakeup");
    endtask

    task automatic back_pressure;
        op_rec_t r[IQ_ENTRIES];
        alu_reg_issue_ready = 1'b0;
        mdu_issue_ready = 1'b0;
        // two mdu ops at the bottom, alu ops above
        for (int k = 0; k < IQ_ENTRIES; k++) begin
            r[k] = random_op(k < 2, 30 + k);
            enqueue(r[k]);
        end
        #10;
        check_bit("enq_ready", enq_ready, 1'b0);
        check_bit("mdu_issue_valid", mdu_issue_valid, 1'b0);
        @(negedge CLK);
        alu_reg_issue_ready = 1'b1;
        #10;
        check_issued(r[2], 1'b0, 1'b0);
        check_bit("enq_ready", enq_ready, 1'b0);
        @(negedge CLK);
        #10;
        check_bit("enq_ready", enq_ready, 1'b1);
        check_issued(r[3], 1'b0, 1'b0);
        @(negedge CLK);
        alu_reg_issue_ready = 1'b0;
        mdu_issue_ready = 1'b1;
        wait_issue(1'b1);
        check_issued(r[0], 1'b0, 1'b0);
        @(negedge CLK);
        #10;
        check_issued(r[1], 1'b0, 1'b0);
        @(negedge CLK);
        drain_queue();
        close_test("back-pressure");
    endtask

    task automatic zero_operands;
        op_rec_t r;
        op_rec_t s;
        alu_reg_issue_ready = 1'b1;
        mdu_issue_ready = 1'b1;
        r = random_op(1'b0, 50);
        r.a_ready = 1'b0;
        r.a_zero = 1'b1;
        r.b_ready = 1'b0;
        r.b_zero = 1'b1;
        s = random_op(1'b1, 51);
        s.a_ready = 1'b0;
        s.a_zero = 1'b1;
        enqueue(r);
        #10;
        check_issued(r, 1'b0, 1'b0);
        @(negedge CLK);
        #10;
        check_read_ports(r, 1'b0, 1'b0);
        @(negedge CLK);
        enqueue(s);
        #10;
        check_issued(s, 1'b0, 1'b0);
        @(negedge CLK);
        #10;
        check_read_ports(s, 1'b0, 1'b0);
        @(negedge CLK);
        close_test("zero operands");
    endtask

    // ----------------------------------------
    // main sequence

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        rng = 32'h2d64b4f7;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        test_start = 0;
        enq_valid = 1'b0;
        {enq_is_alu_reg, enq_is_mdu, enq_op, enq_a_pr, enq_a_ready, enq_a_is_zero} = '0;
        {enq_b_pr, enq_b_ready, enq_b_is_zero, enq_dest_pr, enq_rob_index} = '0;
        wb_valid_by_bank = '0;
        wb_upper_pr_by_bank = '0;
        alu_reg_issue_ready = 1'b0;
        mdu_issue_ready = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        after_reset();
        single_alu_op();
        oldest_first();
        writeback_wakeup();
        back_pressure();
        zero_operands();

        $display("tests: 6, failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
